// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    localparam int IMM_W = 16; // Width of the immediate field.

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_shl,
        op_shr,
        op_mov,
        op_ldi,
        op_cmpeq,
        op_cmplt,
        op_cmpgt,
        op_fnot,
        op_fand,
        op_fmov,
        op_jmp,
        op_jmpf
    } exec_op_e;

    // Compares and flag logic both end in the flag bank.
    function automatic logic op_is_flag(exec_op_e op);
        logic res;
        res = op inside {op_cmpeq, op_cmplt, op_cmpgt, op_fnot, op_fand, op_fmov};
        return res;
    endfunction

    function automatic logic op_is_jump(exec_op_e op);
        logic res;
        res = op inside {op_jmp, op_jmpf};
        return res;
    endfunction

    // Anything that is neither a flag nor a jump writes a register.
    function automatic logic op_is_wb(exec_op_e op);
        return !op_is_flag(op) && !op_is_jump(op);
    endfunction

endpackage : exec_pkg

// ==== verilog/exec_stage_if.sv ====
interface exec_stage_if import exec_pkg::*; #(
    parameter int DATA_W   = 32,
    parameter int REG_CNT  = 8,
    parameter int FLAG_CNT = 4
);
    localparam int REG_AW  = $clog2(REG_CNT);
    localparam int FLAG_AW = $clog2(FLAG_CNT);

    logic                valid;
    exec_op_e            op;
    logic [REG_AW-1:0]   rd;
    logic [DATA_W-1:0]   rs1_data;
    logic [DATA_W-1:0]   rs2_data;
    logic [IMM_W-1:0]    imm;
    logic                high_sel;
    logic [FLAG_AW-1:0]  fd; // Flag indices are the register fields modulo FLAG_CNT.
    logic [FLAG_AW-1:0]  fa;
    logic [FLAG_AW-1:0]  fb;

    modport ctrl (
        output valid, op, rd, rs1_data, rs2_data, imm, high_sel, fd, fa, fb
    );

    modport unit (
        input valid, op, rd, rs1_data, rs2_data, imm, high_sel, fd, fa, fb
    );

endinterface : exec_stage_if

// ==== verilog/exec_ctrl.sv ====
module exec_ctrl import exec_pkg::*; #(
    parameter int DATA_W   = 32,
    parameter int REG_CNT  = 8,
    parameter int FLAG_CNT = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  exec_op_e                     opcode,
    input  logic [$clog2(REG_CNT)-1:0]   rd,
    input  logic [$clog2(REG_CNT)-1:0]   rs1,
    input  logic [$clog2(REG_CNT)-1:0]   rs2,
    input  logic [IMM_W-1:0]             imm,
    input  logic                         high_sel,
    output logic [$clog2(REG_CNT)-1:0]   rs1_addr,
    output logic [$clog2(REG_CNT)-1:0]   rs2_addr,
    input  logic [DATA_W-1:0]            rs1_data,
    input  logic [DATA_W-1:0]            rs2_data,
    exec_stage_if.ctrl                   stage,
    input  logic [DATA_W-1:0]            alu_result,
    input  logic                         flag_result,
    input  logic [$clog2(FLAG_CNT)-1:0]  flag_idx,
    input  logic                         jump_take,
    input  logic [DATA_W-1:0]            jump_target,
    output logic                         wb_valid,
    output logic [$clog2(REG_CNT)-1:0]   wb_addr,
    output logic [DATA_W-1:0]            wb_data,
    output logic                         flag_valid,
    output logic [$clog2(FLAG_CNT)-1:0]  flag_addr,
    output logic                         flag_data,
    output logic                         jump_valid,
    output logic [DATA_W-1:0]            jump_addr
);
    localparam int FLAG_AW = $clog2(FLAG_CNT);

    logic              stage_wb;
    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;
    assign stage_wb = stage.valid && op_is_wb(stage.op);

    // The register file is written from the output registers, so the two newer results
    // are forwarded here. The stage result wins since it is the younger one.
    assign op1 = (stage_wb && stage.rd == rs1) ? alu_result :
                 (wb_valid && wb_addr == rs1)  ? wb_data    : rs1_data;
    assign op2 = (stage_wb && stage.rd == rs2) ? alu_result :
                 (wb_valid && wb_addr == rs2)  ? wb_data    : rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
            wb_valid    <= 1'b0;
            flag_valid  <= 1'b0;
            jump_valid  <= 1'b0;
        end else begin
            stage.valid <= instr_valid;
            wb_valid    <= stage_wb;
            flag_valid  <= stage.valid && op_is_flag(stage.op);
            jump_valid  <= stage.valid && op_is_jump(stage.op)
                           && jump_take; // False op_jmpf stays quiet.
        end
    end

    always_ff @(posedge clk) begin
        stage.op       <= opcode;
        stage.rd       <= rd;
        stage.rs1_data <= op1;
        stage.rs2_data <= op2;
        stage.imm      <= imm;
        stage.high_sel <= high_sel;
        stage.fd       <= rd[FLAG_AW-1:0];
        stage.fa       <= rs1[FLAG_AW-1:0];
        stage.fb       <= rs2[FLAG_AW-1:0];
        wb_addr        <= stage.rd;
        wb_data        <= alu_result;
        flag_addr      <= flag_idx;
        flag_data      <= flag_result;
        jump_addr      <= jump_target;
    end

endmodule : exec_ctrl

// ==== verilog/reg_file.sv ====
module reg_file #(
    parameter int DATA_W  = 32,
    parameter int REG_CNT = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(REG_CNT)-1:0]  rs1_addr,
    input  logic [$clog2(REG_CNT)-1:0]  rs2_addr,
    output logic [DATA_W-1:0]           rs1_data,
    output logic [DATA_W-1:0]           rs2_data,
    input  logic                        we,
    input  logic [$clog2(REG_CNT)-1:0]  waddr,
    input  logic [DATA_W-1:0]           wdata
);
    logic [DATA_W-1:0] regs [REG_CNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0; // Every register reads zero after reset.
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr]; // Reads are asynchronous.
    assign rs2_data = regs[rs2_addr];

endmodule : reg_file

// ==== verilog/int_alu.sv ====
module int_alu import exec_pkg::*; #(
    parameter int DATA_W = 32
) (
    exec_stage_if.unit        stage,
    output logic [DATA_W-1:0] alu_result
);
    localparam int SH_W = $clog2(DATA_W);

    logic              sub;
    logic [DATA_W-1:0] b_eff;
    logic [DATA_W:0]   carry;
    logic [DATA_W-1:0] sum;
    logic              sh_big;
    logic [SH_W-1:0]   sh_amt;
    logic [DATA_W-1:0] shl_res;
    logic [DATA_W-1:0] shr_res;
    logic [DATA_W-1:0] ldi_res;

    assign sub   = (stage.op == op_sub);
    assign b_eff = sub ? ~stage.rs2_data : stage.rs2_data; // Subtract is a plus ~b plus one.

    // Ripple carry chain, one full adder per bit.
    always_comb begin
        carry[0] = sub;
        for (int i = 0; i < DATA_W; i++) begin
            sum[i]     = stage.rs1_data[i] ^ b_eff[i] ^ carry[i];
            carry[i+1] = (stage.rs1_data[i] & b_eff[i]) |
                         (stage.rs1_data[i] & carry[i]) |
                         (b_eff[i] & carry[i]);
        end
    end

    assign sh_big  = |stage.rs2_data[DATA_W-1:SH_W]; // Amounts of DATA_W or more clear the word.
    assign sh_amt  = stage.rs2_data[SH_W-1:0];
    assign shl_res = sh_big ? '0 : stage.rs1_data << sh_amt;
    assign shr_res = sh_big ? '0 : stage.rs1_data >> sh_amt;

    assign ldi_res = stage.high_sel ?
                     {stage.imm, stage.rs1_data[DATA_W-IMM_W-1:0]} :
                     {stage.rs1_data[DATA_W-1:IMM_W], stage.imm};

    always_comb begin
        case (stage.op)
            op_add,
            op_sub:  alu_result = sum;
            op_shl:  alu_result = shl_res;
            op_shr:  alu_result = shr_res;
            op_mov:  alu_result = stage.rs1_data;
            op_ldi:  alu_result = ldi_res;
            default: alu_result = '0;
        endcase
    end

endmodule : int_alu

// ==== verilog/flag_branch_unit.sv ====
module flag_branch_unit import exec_pkg::*; #(
    parameter int DATA_W   = 32,
    parameter int FLAG_CNT = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    exec_stage_if.unit                   stage,
    output logic                         flag_result,
    output logic [$clog2(FLAG_CNT)-1:0]  flag_idx,
    output logic                         jump_take,
    output logic [DATA_W-1:0]            jump_target
);
    logic [FLAG_CNT-1:0] flags;
    logic                flag_we;

    assign flag_we = stage.valid && op_is_flag(stage.op);

    // The bank takes the result as the instruction leaves the stage. A flag op right behind
    // reads it during its own stage cycle, so no forwarding is needed here.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_we) begin
            flags[stage.fd] <= flag_result;
        end
    end

    always_comb begin
        case (stage.op)
            op_cmpeq: flag_result = (stage.rs1_data == stage.rs2_data);
            op_cmplt: flag_result = (stage.rs1_data < stage.rs2_data); // Unsigned compares.
            op_cmpgt: flag_result = (stage.rs1_data > stage.rs2_data);
            op_fnot:  flag_result = ~flags[stage.fa];
            op_fand:  flag_result = flags[stage.fa] & flags[stage.fb];
            op_fmov:  flag_result = flags[stage.fa];
            default:  flag_result = 1'b0;
        endcase
    end

    assign flag_idx = stage.fd;

    always_comb begin
        case (stage.op)
            op_jmp:  jump_take = 1'b1;
            op_jmpf: jump_take = flags[stage.fd]; // Condition is flag rd.
            default: jump_take = 1'b0;
        endcase
    end

    assign jump_target = stage.rs1_data;

endmodule : flag_branch_unit

// ==== verilog/exec_top.sv ====
module exec_top import exec_pkg::*; #(
    parameter int DATA_W   = 32,
    parameter int REG_CNT  = 8,
    parameter int FLAG_CNT = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  exec_op_e                     opcode,
    input  logic [$clog2(REG_CNT)-1:0]   rd,
    input  logic [$clog2(REG_CNT)-1:0]   rs1,
    input  logic [$clog2(REG_CNT)-1:0]   rs2,
    input  logic [IMM_W-1:0]             imm,
    input  logic                         high_sel,
    output logic                         wb_valid,
    output logic [$clog2(REG_CNT)-1:0]   wb_addr,
    output logic [DATA_W-1:0]            wb_data,
    output logic                         flag_valid,
    output logic [$clog2(FLAG_CNT)-1:0]  flag_addr,
    output logic                         flag_data,
    output logic                         jump_valid,
    output logic [DATA_W-1:0]            jump_addr
);
    logic [$clog2(REG_CNT)-1:0]  rs1_addr;
    logic [$clog2(REG_CNT)-1:0]  rs2_addr;
    logic [DATA_W-1:0]           rs1_data;
    logic [DATA_W-1:0]           rs2_data;
    logic [DATA_W-1:0]           alu_result;
    logic                        flag_result;
    logic [$clog2(FLAG_CNT)-1:0] flag_idx;
    logic                        jump_take;
    logic [DATA_W-1:0]           jump_target;

    exec_stage_if #(.DATA_W(DATA_W), .REG_CNT(REG_CNT), .FLAG_CNT(FLAG_CNT)) stage ();

    exec_ctrl #(.DATA_W(DATA_W), .REG_CNT(REG_CNT), .FLAG_CNT(FLAG_CNT)) u_ctrl (
        .clk, .rst_n, .instr_valid, .opcode, .rd, .rs1, .rs2, .imm, .high_sel,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .stage(stage.ctrl),
        .alu_result, .flag_result, .flag_idx, .jump_take, .jump_target,
        .wb_valid, .wb_addr, .wb_data, .flag_valid, .flag_addr, .flag_data,
        .jump_valid, .jump_addr
    );

    reg_file #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_reg_file (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we(wb_valid), .waddr(wb_addr), .wdata(wb_data)
    );

    int_alu #(.DATA_W(DATA_W)) u_alu (.stage(stage.unit), .alu_result);

    flag_branch_unit #(.DATA_W(DATA_W), .FLAG_CNT(FLAG_CNT)) u_flag_branch (
        .clk, .rst_n, .stage(stage.unit), .flag_result, .flag_idx, .jump_take, .jump_target
    );

endmodule : exec_top

// ==== verif/exec_asserts.sv ====
module exec_asserts (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic wb_valid,
    input logic flag_valid,
    input logic jump_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] strobes;

    assign strobes = {wb_valid, flag_valid, jump_valid};

    // Each instruction belongs to exactly one result class.
    one_strobe: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(strobes))
        else $error("More than one output strobe is high.");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> strobes == 3'b000)
        else $error("An output strobe is high during reset.");

    // Two sampled edges lie between the instruction and its visible strobe.
    strobe_has_instr: assert property (@(posedge clk) disable iff (!rst_n)
        (|strobes) |-> $past(instr_valid, 2))
        else $error("An output strobe has no instruction before it.");

endmodule : exec_asserts

bind exec_top exec_asserts u_asserts (
    .clk, .rst_n, .instr_valid, .wb_valid, .flag_valid, .jump_valid
);

// ==== verif/exec_tb.sv ====
module exec_tb import exec_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W       = 32;
    localparam int REG_CNT      = 8;
    localparam int FLAG_CNT     = 4;
    localparam int REG_AW       = $clog2(REG_CNT);
    localparam int FLAG_AW      = $clog2(FLAG_CNT);
    localparam int RESET_CYCLES = 4;
    localparam int N_RANDOM     = 300;
    localparam int N_CMP        = 18;
    localparam int N_FLAG       = 40;
    localparam int N_JUMP       = 40;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 3 * REG_CNT + N_RANDOM + N_CMP
                                  + N_FLAG + N_JUMP + 6;
    localparam int MAX_CYCLES   = TEST_CYCLES + 50;

    typedef enum logic [1:0] {kind_none, kind_wb, kind_flag, kind_jump} kind_e;

    typedef struct {
        kind_e             kind;
        logic [31:0]       addr;
        logic [DATA_W-1:0] data;
        int                due;
    } expect_t;

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    exec_op_e             opcode;
    logic [REG_AW-1:0]    rd;
    logic [REG_AW-1:0]    rs1;
    logic [REG_AW-1:0]    rs2;
    logic [IMM_W-1:0]     imm;
    logic                 high_sel;
    logic                 wb_valid;
    logic [REG_AW-1:0]    wb_addr;
    logic [DATA_W-1:0]    wb_data;
    logic                 flag_valid;
    logic [FLAG_AW-1:0]   flag_addr;
    logic                 flag_data;
    logic                 jump_valid;
    logic [DATA_W-1:0]    jump_addr;

    integer               seed;
    int                   cycles = 0;
    expect_t              exp_q[$];
    logic [DATA_W-1:0]    model_regs [REG_CNT];
    logic [FLAG_CNT-1:0]  model_flags;

    exec_top #(.DATA_W(DATA_W), .REG_CNT(REG_CNT), .FLAG_CNT(FLAG_CNT)) UUT (
        .clk, .rst_n, .instr_valid, .opcode, .rd, .rs1, .rs2, .imm, .high_sel,
        .wb_valid, .wb_addr, .wb_data, .flag_valid, .flag_addr, .flag_data,
        .jump_valid, .jump_addr
    );

    always #20 clk = ~clk; // 40 ns period.

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // Reference model. It updates the model state in program order and returns the strobe.
    function automatic expect_t predict_result(input exec_op_e op, input logic [REG_AW-1:0] d,
            input logic [REG_AW-1:0] s1, input logic [REG_AW-1:0] s2,
            input logic [IMM_W-1:0] im, input logic hs);
        expect_t            e;
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  b;
        logic [FLAG_AW-1:0] fd;
        logic [FLAG_AW-1:0] fa;
        logic [FLAG_AW-1:0] fb;
        a = model_regs[s1];
        b = model_regs[s2];
        fd = d[FLAG_AW-1:0];
        fa = s1[FLAG_AW-1:0];
        fb = s2[FLAG_AW-1:0];
        e.kind = kind_wb;
        e.addr = 32'(d);
        e.data = '0;
        e.due = 0;
        case (op)
            op_add:   e.data = a + b;
            op_sub:   e.data = a - b;
            op_shl:   e.data = (b >= DATA_W) ? '0 : a << b;
            op_shr:   e.data = (b >= DATA_W) ? '0 : a >> b;
            op_mov:   e.data = a;
            op_ldi:   e.data = hs ? {im, a[DATA_W-IMM_W-1:0]} : {a[DATA_W-1:IMM_W], im};
            op_cmpeq: model_flags[fd] = (a == b);
            op_cmplt: model_flags[fd] = (a < b);
            op_cmpgt: model_flags[fd] = (a > b);
            op_fnot:  model_flags[fd] = ~model_flags[fa];
            op_fand:  model_flags[fd] = model_flags[fa] & model_flags[fb];
            op_fmov:  model_flags[fd] = model_flags[fa];
            op_jmp:   e.kind = kind_jump;
            op_jmpf:  e.kind = model_flags[fd] ? kind_jump : kind_none;
            default:  e.kind = kind_none;
        endcase
        if (op inside {op_cmpeq, op_cmplt, op_cmpgt, op_fnot, op_fand, op_fmov}) begin
            e.kind = kind_flag;
            e.addr = 32'(fd);
            e.data = DATA_W'(model_flags[fd]);
        end else if (e.kind == kind_wb) begin
            model_regs[d] = e.data;
        end else begin
            e.data = a; // Jump target is the rs1 value.
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] want);
        if (got !== want) begin
            $display("** Error @ %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("Checks failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic issue(input exec_op_e op, input logic [REG_AW-1:0] d,
            input logic [REG_AW-1:0] s1, input logic [REG_AW-1:0] s2,
            input logic [IMM_W-1:0] im, input logic hs);
        expect_t e;
        e = predict_result(op, d, s1, s2, im, hs);
        e.due = cycles + 2; // Sampled at the next edge, visible after the one after.
        if (e.kind != kind_none) begin
            exp_q.push_back(e);
        end
        instr_valid = 1'b1;
        opcode      = op;
        rd          = d;
        rs1         = s1;
        rs2         = s2;
        imm         = im;
        high_sel    = hs;
        @(posedge clk);
        #2;
    endtask

    task automatic idle();
        instr_valid = 1'b0;
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // Outputs change at the rising edge, so they are compared in the middle of the cycle.
    always @(negedge clk) begin
        expect_t e;
        if (cycles > 0) begin
            e.kind = kind_none;
            e.addr = '0;
            e.data = '0;
            e.due = 0;
            if (exp_q.size() > 0 && exp_q[0].due == cycles) begin
                e = exp_q.pop_front();
            end
            check_value("wb_valid", 32'(wb_valid), 32'(e.kind == kind_wb));
            check_value("flag_valid", 32'(flag_valid), 32'(e.kind == kind_flag));
            check_value("jump_valid", 32'(jump_valid), 32'(e.kind == kind_jump));
            if (e.kind == kind_wb) begin
                check_value("wb_addr", 32'(wb_addr), e.addr);
                check_value("wb_data", wb_data, e.data);
            end else if (e.kind == kind_flag) begin
                check_value("flag_addr", 32'(flag_addr), e.addr);
                check_value("flag_data", 32'(flag_data), e.data);
            end else if (e.kind == kind_jump) begin
                check_value("jump_addr", jump_addr, e.data);
            end
        end
    end

    initial begin
        int                sel;
        logic [REG_AW-1:0] d;
        logic [REG_AW-1:0] s1;
        logic [REG_AW-1:0] s2;
        seed        = 4;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        opcode      = op_add;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        high_sel    = 1'b0;
        model_flags = '0;
        for (int r = 0; r < REG_CNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle();
        idle();
        for (int r = 0; r < REG_CNT; r++) begin
            issue(op_mov, REG_AW'(r), REG_AW'(r), '0, '0, 1'b0);
        end
        // The last register stays zero and feeds small shift amounts later.
        for (int r = 0; r < REG_CNT; r++) begin
            d = REG_AW'(r);
            issue(op_ldi, d, d, '0, (r == REG_CNT - 1) ? '0 : IMM_W'(rand_below(65536)), 1'b0);
            issue(op_ldi, d, d, '0, (r == REG_CNT - 1) ? '0 : IMM_W'(rand_below(65536)), 1'b1);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = rand_below(8);
            d = REG_AW'(rand_below(REG_CNT - 1));
            s1 = REG_AW'(rand_below(REG_CNT));
            s2 = REG_AW'(rand_below(REG_CNT));
            case (sel)
                0:       issue(op_add, d, s1, s2, '0, 1'b0);
                1, 7:    issue(op_sub, d, s1, s2, '0, 1'b0);
                2:       issue(op_shl, d, s1, s2, '0, 1'b0);
                3:       issue(op_shr, d, s1, s2, '0, 1'b0);
                4:       issue(op_mov, d, s1, s2, '0, 1'b0);
                5:       issue(op_ldi, d, s1, s2, IMM_W'(rand_below(65536)), rand_below(2) == 1);
                default: issue(op_ldi, d, REG_AW'(REG_CNT - 1), s2, IMM_W'(rand_below(64)), 1'b0);
            endcase
        end
        for (int i = 0; i < N_CMP; i++) begin
            d = REG_AW'(rand_below(REG_CNT));
            s1 = REG_AW'(rand_below(REG_CNT));
            s2 = (i % 6 < 2) ? s1 : REG_AW'(rand_below(REG_CNT)); // Same register means equal.
            case (i % 3)
                0:       issue(op_cmpeq, d, s1, s2, '0, 1'b0);
                1:       issue(op_cmplt, d, s1, s2, '0, 1'b0);
                default: issue(op_cmpgt, d, s1, s2, '0, 1'b0);
            endcase
        end
        for (int i = 0; i < N_FLAG; i++) begin
            sel = rand_below(3);
            d = REG_AW'(rand_below(REG_CNT));
            s1 = REG_AW'(rand_below(REG_CNT));
            s2 = REG_AW'(rand_below(REG_CNT));
            case (sel)
                0:       issue(op_fnot, d, s1, s2, '0, 1'b0);
                1:       issue(op_fand, d, s1, s2, '0, 1'b0);
                default: issue(op_fmov, d, s1, s2, '0, 1'b0);
            endcase
        end
        for (int i = 0; i < N_JUMP; i++) begin
            sel = rand_below(5);
            d = REG_AW'(rand_below(REG_CNT));
            s1 = REG_AW'(rand_below(REG_CNT));
            s2 = REG_AW'(rand_below(REG_CNT));
            case (sel)
                0:       issue(op_jmp, d, s1, s2, '0, 1'b0);
                1, 2:    issue(op_jmpf, d, s1, s2, '0, 1'b0);
                3:       issue(op_cmplt, d, s1, s2, '0, 1'b0);
                default: issue(op_fnot, d, s1, s2, '0, 1'b0);
            endcase
        end
        idle();
        while (exp_q.size() > 0) begin
            idle();
        end
        repeat (3) idle(); // A final false op_jmpf has no queue entry but is still checked.
        $display("All checks passed");
        $finish;
    end

endmodule : exec_tb

// ==== build.f ====
verilog/exec_pkg.sv
verilog/exec_stage_if.sv
verilog/exec_ctrl.sv
verilog/reg_file.sv
verilog/int_alu.sv
verilog/flag_branch_unit.sv
verilog/exec_top.sv
verif/exec_asserts.sv
verif/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f build.f --top-module exec_tb -o exec_sim \
    && ./obj_dir/exec_sim \
    || exit 1
